//--- include/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// lanes in one request group
`define DC_LANES 4

// banks, one word of each line per bank
`define DC_BANKS 4

// direct-mapped sets
`define DC_SETS 16

// address field start bits
`define DC_BANK_LSB  2
`define DC_INDEX_LSB 4
`define DC_TAG_LSB   8

// clears the word offset of a line address
`define DC_LINE_MASK 32'hffff_fff0

`endif

//--- src/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    // field widths derived from the address layout
    localparam int LANE_W  = $clog2(`DC_LANES);
    localparam int BANK_W  = `DC_INDEX_LSB - `DC_BANK_LSB;
    localparam int INDEX_W = `DC_TAG_LSB - `DC_INDEX_LSB;
    localparam int TAG_W   = 32 - `DC_TAG_LSB;

    // one lane's request, word address only
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
    } lane_req_t;

    // whole line, word[b] lives in bank b
    typedef struct packed {
        logic [`DC_BANKS-1:0][31:0] word;
    } mem_line_t;

    // combined write-back plus fill transaction
    typedef struct packed {
        logic [31:0] victim_addr;
        logic [31:0] fill_addr;
        logic        wb;          // victim line goes back first
        mem_line_t   victim_data;
    } mem_req_t;

    // lane picked by the arbiter for one bank
    typedef struct packed {
        logic              valid;
        logic [LANE_W-1:0] lane;
    } bank_sel_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_REQ,
        MS_RELEASE
    } miss_state_e;

endpackage

//--- src/dcache_lane_arbiter.sv
`include "dcache_defines.svh"

module dcache_lane_arbiter (
    input  logic [`DC_LANES-1:0]                       i_valid,
    input  dcache_pkg::lane_req_t [`DC_LANES-1:0]      i_req,
    output dcache_pkg::bank_sel_t [`DC_BANKS-1:0]      o_sel
);

    // lanes that want each bank
    logic [`DC_BANKS-1:0][`DC_LANES-1:0] bank_mask;

    always_comb begin
        for (int b = 0; b < `DC_BANKS; b++) begin
            for (int l = 0; l < `DC_LANES; l++) begin
                bank_mask[b][l] = i_valid[l] &&
                    (i_req[l].addr[`DC_INDEX_LSB-1:`DC_BANK_LSB] == dcache_pkg::BANK_W'(b));
            end
        end
    end

    // fixed priority, lowest lane wins
    always_comb begin
        for (int b = 0; b < `DC_BANKS; b++) begin
            o_sel[b] = '0;
            for (int l = `DC_LANES - 1; l >= 0; l--) begin
                if (bank_mask[b][l]) begin
                    o_sel[b].valid = 1'b1;
                    o_sel[b].lane  = dcache_pkg::LANE_W'(l);
                end
            end
        end
    end

endmodule

//--- src/dcache_bank.sv
`include "dcache_defines.svh"

module dcache_bank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_lookup,
    input  logic                           i_write,
    input  logic [dcache_pkg::INDEX_W-1:0] i_index,
    input  logic [dcache_pkg::TAG_W-1:0]   i_tag,
    input  logic [31:0]                    i_wdata,
    input  logic                           i_fill,
    input  logic [dcache_pkg::INDEX_W-1:0] i_fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]   i_fill_tag,
    input  logic [31:0]                    i_fill_data,
    output logic                           o_hit,
    output logic [31:0]                    o_rdata,
    output logic [dcache_pkg::TAG_W-1:0]   o_victim_tag,
    output logic                           o_victim_dirty,
    output logic [31:0]                    o_victim_data
);

    logic [`DC_SETS-1:0]          valid_q;
    logic [`DC_SETS-1:0]          dirty_q;
    logic [dcache_pkg::TAG_W-1:0] tag_mem [`DC_SETS];
    logic [31:0]                  data_mem [`DC_SETS];
    logic                         wr_hit;

    // combinational lookup
    assign o_hit   = i_lookup && valid_q[i_index] && (tag_mem[i_index] == i_tag);
    assign wr_hit  = o_hit && i_write;
    assign o_rdata = data_mem[i_index];

    // entry at the looked-up index, used when it gets evicted
    assign o_victim_tag   = tag_mem[i_index];
    assign o_victim_dirty = valid_q[i_index] && dirty_q[i_index];
    assign o_victim_data  = data_mem[i_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fill) begin
            valid_q[i_fill_index] <= 1'b1;
            dirty_q[i_fill_index] <= 1'b0;   // fresh copy of memory
        end else if (wr_hit) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    // fill and lookup never overlap, lookups are held off while a miss runs
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_fill_index]  <= i_fill_tag;
            data_mem[i_fill_index] <= i_fill_data;
        end else if (wr_hit) begin
            data_mem[i_index] <= i_wdata;
        end
    end

endmodule

//--- src/dcache_miss_ctrl.sv
`include "dcache_defines.svh"

module dcache_miss_ctrl (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [`DC_BANKS-1:0]                           i_miss,
    input  logic [`DC_BANKS-1:0][31:0]                     i_addr,
    input  logic [`DC_BANKS-1:0][dcache_pkg::TAG_W-1:0]    i_victim_tag,
    input  logic [`DC_BANKS-1:0]                           i_victim_dirty,
    input  logic [`DC_BANKS-1:0][31:0]                     i_victim_data,
    input  logic                                           i_mem_ack,
    input  dcache_pkg::mem_line_t                          i_mem_rdata,
    output logic                                           o_mem_req,
    output dcache_pkg::mem_req_t                           o_mem_pkt,
    output logic                                           o_fill,
    output logic [dcache_pkg::INDEX_W-1:0]                 o_fill_index,
    output logic [dcache_pkg::TAG_W-1:0]                   o_fill_tag,
    output dcache_pkg::mem_line_t                          o_fill_data,
    output logic                                           o_busy
);

    dcache_pkg::miss_state_e  state_q;
    dcache_pkg::miss_state_e  state_d;
    logic [dcache_pkg::BANK_W-1:0] miss_bank;
    logic                     start;
    logic [31:0]              fill_addr_q;
    logic [31:0]              victim_addr_q;

    // lowest bank that missed
    always_comb begin
        miss_bank = '0;
        for (int b = `DC_BANKS - 1; b >= 0; b--) begin
            if (i_miss[b]) begin
                miss_bank = dcache_pkg::BANK_W'(b);
            end
        end
    end

    assign start = (state_q == dcache_pkg::MS_IDLE) && (|i_miss);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::MS_IDLE:    if (start) state_d = dcache_pkg::MS_REQ;
            dcache_pkg::MS_REQ:     if (i_mem_ack) state_d = dcache_pkg::MS_RELEASE;
            dcache_pkg::MS_RELEASE: if (!i_mem_ack) state_d = dcache_pkg::MS_IDLE;
            default:                state_d = dcache_pkg::MS_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= dcache_pkg::MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line addresses captured in the miss cycle
    always_ff @(posedge clk) begin
        if (start) begin
            fill_addr_q   <= i_addr[miss_bank] & `DC_LINE_MASK;
            victim_addr_q <= {i_victim_tag[miss_bank],
                              i_addr[miss_bank][`DC_TAG_LSB-1:`DC_INDEX_LSB],
                              {`DC_INDEX_LSB{1'b0}}};
        end
    end

    // banks sit on the fill index while busy, so all words belong to the victim
    always_comb begin
        o_mem_pkt.victim_addr      = victim_addr_q;
        o_mem_pkt.fill_addr        = fill_addr_q;
        o_mem_pkt.wb               = |i_victim_dirty;   // any dirty word sends the line back
        o_mem_pkt.victim_data.word = i_victim_data;
    end

    assign o_mem_req = (state_q == dcache_pkg::MS_REQ);
    assign o_busy    = (state_q != dcache_pkg::MS_IDLE);

    // one-cycle strobe on the first ack
    assign o_fill       = (state_q == dcache_pkg::MS_REQ) && i_mem_ack;
    assign o_fill_index = fill_addr_q[`DC_TAG_LSB-1:`DC_INDEX_LSB];
    assign o_fill_tag   = fill_addr_q[31:`DC_TAG_LSB];
    assign o_fill_data  = i_mem_rdata;

endmodule

//--- src/dcache_top.sv
`include "dcache_defines.svh"

module dcache_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [`DC_LANES-1:0]                   i_p_valid,
    input  dcache_pkg::lane_req_t [`DC_LANES-1:0]  i_p_req,
    input  logic                                   i_p_write,
    output logic [`DC_LANES-1:0][31:0]             o_p_rdata,
    output logic                                   o_p_delay,
    output logic                                   o_mem_req,
    output dcache_pkg::mem_req_t                   o_mem_pkt,
    input  logic                                   i_mem_ack,
    input  dcache_pkg::mem_line_t                  i_mem_rdata
);

    logic [`DC_LANES-1:0]                        stored_q;
    logic [`DC_LANES-1:0]                        use_valid;
    logic [`DC_LANES-1:0]                        served;
    logic [`DC_LANES-1:0]                        next_stored;
    logic [`DC_LANES-1:0][31:0]                  result_q;
    logic [`DC_LANES-1:0][31:0]                  new_data;

    dcache_pkg::bank_sel_t [`DC_BANKS-1:0]       sel;
    logic [`DC_BANKS-1:0][31:0]                  bank_addr;
    logic [`DC_BANKS-1:0][31:0]                  bank_rdata;
    logic [`DC_BANKS-1:0]                        lookup;
    logic [`DC_BANKS-1:0]                        hit;
    logic [`DC_BANKS-1:0]                        miss;
    logic [`DC_BANKS-1:0][dcache_pkg::TAG_W-1:0] victim_tag;
    logic [`DC_BANKS-1:0]                        victim_dirty;
    logic [`DC_BANKS-1:0][31:0]                  victim_data;

    logic                                        busy;
    logic                                        fill;
    logic [dcache_pkg::INDEX_W-1:0]              fill_index;
    logic [dcache_pkg::TAG_W-1:0]                fill_tag;
    dcache_pkg::mem_line_t                       fill_data;

    // a new group is taken only when nothing is left over
    assign use_valid = (stored_q == '0) ? i_p_valid : stored_q;

    dcache_lane_arbiter u_arbiter (
        .i_valid (use_valid),
        .i_req   (i_p_req),
        .o_sel   (sel)
    );

    for (genvar b = 0; b < `DC_BANKS; b++) begin : g_bank
        logic [dcache_pkg::INDEX_W-1:0] index;

        assign bank_addr[b] = i_p_req[sel[b].lane].addr;
        assign lookup[b]    = sel[b].valid && !busy;   // no lookups during a miss
        assign miss[b]      = lookup[b] && !hit[b];
        // victim read-out and fill both use the miss index
        assign index = busy ? fill_index : bank_addr[b][`DC_TAG_LSB-1:`DC_INDEX_LSB];

        dcache_bank u_bank (
            .clk            (clk),
            .rst            (rst),
            .i_lookup       (lookup[b]),
            .i_write        (i_p_write),
            .i_index        (index),
            .i_tag          (bank_addr[b][31:`DC_TAG_LSB]),
            .i_wdata        (i_p_req[sel[b].lane].wdata),
            .i_fill         (fill),
            .i_fill_index   (fill_index),
            .i_fill_tag     (fill_tag),
            .i_fill_data    (fill_data.word[b]),
            .o_hit          (hit[b]),
            .o_rdata        (bank_rdata[b]),
            .o_victim_tag   (victim_tag[b]),
            .o_victim_dirty (victim_dirty[b]),
            .o_victim_data  (victim_data[b])
        );
    end

    dcache_miss_ctrl u_miss_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_miss         (miss),
        .i_addr         (bank_addr),
        .i_victim_tag   (victim_tag),
        .i_victim_dirty (victim_dirty),
        .i_victim_data  (victim_data),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rdata    (i_mem_rdata),
        .o_mem_req      (o_mem_req),
        .o_mem_pkt      (o_mem_pkt),
        .o_fill         (fill),
        .o_fill_index   (fill_index),
        .o_fill_tag     (fill_tag),
        .o_fill_data    (fill_data),
        .o_busy         (busy)
    );

    // hitting banks overwrite their lane, the rest keep earlier results
    always_comb begin
        served   = '0;
        new_data = result_q;
        for (int b = 0; b < `DC_BANKS; b++) begin
            if (hit[b]) begin
                served[sel[b].lane]   = 1'b1;
                new_data[sel[b].lane] = bank_rdata[b];
            end
        end
    end

    assign next_stored = use_valid & ~served;
    assign o_p_rdata   = new_data;
    assign o_p_delay   = (next_stored != '0) || busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stored_q <= '0;
        end else begin
            stored_q <= next_stored;
        end
    end

    always_ff @(posedge clk) begin
        result_q <= new_data;
    end

endmodule

//--- test/dcache_chk.sv
`include "dcache_defines.svh"

module dcache_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      i_mem_req,
    input logic                      i_mem_ack,
    input dcache_pkg::mem_req_t      i_mem_pkt,
    input logic [`DC_LANES-1:0]      i_p_valid,
    input dcache_pkg::miss_state_e   i_state,
    input logic                      i_p_delay
);
    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;   // read by the testbench

    // req may only fall once ack has been seen
    req_held_a: assert property (@(posedge clk) disable iff (rst)
        i_mem_req && !i_mem_ack |=> i_mem_req)
        else begin
            $error("memory req dropped before ack");
            err_count++;
        end

    // a new request waits for the previous ack to go low
    req_after_ack_a: assert property (@(posedge clk) disable iff (rst)
        !i_mem_req && i_mem_ack |=> !i_mem_req)
        else begin
            $error("memory req raised while ack still high");
            err_count++;
        end

    pkt_stable_a: assert property (@(posedge clk) disable iff (rst)
        i_mem_req && $past(i_mem_req) |->
            $stable(i_mem_pkt.fill_addr) && $stable(i_mem_pkt.wb))
        else begin
            $error("fill address or write-back flag changed under req");
            err_count++;
        end

    // victim fields only carry meaning with a write-back
    victim_stable_a: assert property (@(posedge clk) disable iff (rst)
        i_mem_req && $past(i_mem_req) && i_mem_pkt.wb |->
            $stable(i_mem_pkt.victim_addr) && $stable(i_mem_pkt.victim_data))
        else begin
            $error("victim line changed under req");
            err_count++;
        end

    // no lanes asked for and no miss running, so no leftover pending bits
    idle_no_delay_a: assert property (@(posedge clk) disable iff (rst)
        (i_p_valid == '0) && (i_state == dcache_pkg::MS_IDLE) |-> !i_p_delay)
        else begin
            $error("stall raised with no lanes and an idle miss FSM");
            err_count++;
        end

endmodule

bind dcache_top dcache_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .i_mem_req (o_mem_req),
    .i_mem_ack (i_mem_ack),
    .i_mem_pkt (o_mem_pkt),
    .i_p_valid (i_p_valid),
    .i_state   (u_miss_ctrl.state_q),
    .i_p_delay (o_p_delay)
);

//--- test/dcache_tb.sv
`include "dcache_defines.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_HALF   = 4;
    localparam int          FIELDS     = 16;   // hex words per stimulus line
    localparam int          MAX_GROUPS = 64;
    localparam logic [31:0] NO_LINE    = 32'hffff_ffff;

    logic                                  clk;
    logic                                  rst;
    logic [`DC_LANES-1:0]                  i_p_valid;
    dcache_pkg::lane_req_t [`DC_LANES-1:0] i_p_req;
    logic                                  i_p_write;
    logic [`DC_LANES-1:0][31:0]            o_p_rdata;
    logic                                  o_p_delay;
    logic                                  o_mem_req;
    dcache_pkg::mem_req_t                  o_mem_pkt;
    logic                                  i_mem_ack;
    dcache_pkg::mem_line_t                 i_mem_rdata;

    logic [31:0] vec [FIELDS*MAX_GROUPS];
    logic [31:0] mem_words [logic [31:0]];   // only words written back
    int          num_groups;
    int          txn_count;
    int          wb_count;

    dcache_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .i_p_valid   (i_p_valid),
        .i_p_req     (i_p_req),
        .i_p_write   (i_p_write),
        .o_p_rdata   (o_p_rdata),
        .o_p_delay   (o_p_delay),
        .o_mem_req   (o_mem_req),
        .o_mem_pkt   (o_mem_pkt),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ 32'h5a5a0000;   // untouched memory
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // four-phase slave, write-back first and then the fill line
    task automatic respond_memory();
        dcache_pkg::mem_req_t  pkt;
        dcache_pkg::mem_line_t line;
        forever begin
            @(negedge clk);
            if (o_mem_req && !i_mem_ack) begin
                pkt = o_mem_pkt;
                txn_count++;
                repeat (1 + $urandom % 6) @(negedge clk);
                if (pkt.wb) begin
                    wb_count++;
                    for (int b = 0; b < `DC_BANKS; b++) begin
                        mem_words[pkt.victim_addr + 32'(4 * b)] = pkt.victim_data.word[b];
                    end
                end
                for (int b = 0; b < `DC_BANKS; b++) begin
                    line.word[b] = read_word(pkt.fill_addr + 32'(4 * b));
                end
                i_mem_rdata = line;
                i_mem_ack   = 1'b1;
                do begin
                    @(negedge clk);
                end while (o_mem_req);
                repeat (1 + $urandom % 6) @(negedge clk);
                i_mem_ack = 1'b0;
            end
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout: stimulus not finished after %0d cycles", cycles);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic run_group(input int g);
        int base;
        int txn_start;
        int wb_start;
        base      = g * FIELDS;
        txn_start = txn_count;
        wb_start  = wb_count;
        @(negedge clk);
        i_p_write = vec[base][0];
        i_p_valid = vec[base + 1][`DC_LANES-1:0];
        for (int l = 0; l < `DC_LANES; l++) begin
            i_p_req[l].addr  = vec[base + 2 + l];
            i_p_req[l].wdata = vec[base + 6 + l];
        end
        // look just before each rising edge
        #(CLK_HALF - 1);
        while (o_p_delay) begin
            @(negedge clk);
            #(CLK_HALF - 1);
        end
        if (!i_p_write) begin
            for (int l = 0; l < `DC_LANES; l++) begin
                if (i_p_valid[l]) begin
                    check_value($sformatf("group %0d lane %0d read data", g, l),
                                o_p_rdata[l], vec[base + 10 + l]);
                end
            end
        end
        check_value($sformatf("group %0d memory transactions", g),
                    32'(txn_count - txn_start), vec[base + 14]);
        check_value($sformatf("group %0d write-backs", g),
                    32'(wb_count - wb_start), vec[base + 15]);
        @(posedge clk);
    endtask

    // assertion failures in the bound checker end the run
    initial begin
        wait (dut0.u_chk.err_count != 0);
        $display("bound checker flagged a protocol assertion");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h7cf5));
        rst         = 1'b1;
        i_p_valid   = '0;
        i_p_req     = '0;
        i_p_write   = 1'b0;
        i_mem_ack   = 1'b0;
        i_mem_rdata = '0;
        txn_count   = 0;
        wb_count    = 0;
        num_groups  = 0;
        for (int i = 0; i < FIELDS * MAX_GROUPS; i++) begin
            vec[i] = NO_LINE;
        end
        $readmemh("test/dcache_input.txt", vec);
        while (num_groups < MAX_GROUPS && vec[num_groups * FIELDS] !== NO_LINE) begin
            num_groups++;
        end
        if (num_groups == 0) begin
            $display("no stimulus lines found in test/dcache_input.txt");
            $display("** FAIL **");
            $fatal(1);
        end
        fork
            respond_memory();
            run_watchdog(num_groups * 200);
        join_none
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int g = 0; g < num_groups; g++) begin
            run_group(g);
        end
        @(negedge clk);
        i_p_valid = '0;
        if (dut0.u_chk.err_count != 0) begin
            $display("bound checker reported %0d failures", dut0.u_chk.err_count);
            $display("** FAIL **");
            $fatal(1);
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- list.f
+incdir+include
src/dcache_pkg.sv
src/dcache_lane_arbiter.sv
src/dcache_bank.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
test/dcache_chk.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - files:
      - src/dcache_pkg.sv
      - src/dcache_lane_arbiter.sv
      - src/dcache_bank.sv
      - src/dcache_miss_ctrl.sv
      - src/dcache_top.sv
  - target: test
    files:
      - test/dcache_chk.sv
      - test/dcache_tb.sv

//--- test/dcache_input.txt
// op mask addr0 addr1 addr2 addr3 wdata0..3 expected0..3 mem_txns write_backs
// all fields hex, op 1 is a write, expected data only checked on reads
0 f 100 104 108 10c 0 0 0 0 5a5a0100 5a5a0104 5a5a0108 5a5a010c 1 0
0 1 210 0 0 0 0 0 0 0 5a5a0210 0 0 0 1 0
0 f 320 334 348 35c 0 0 0 0 5a5a0320 5a5a0334 5a5a0348 5a5a035c 4 0
// hits on lines already filled
0 f 330 214 218 21c 0 0 0 0 5a5a0330 5a5a0214 5a5a0218 5a5a021c 0 0
0 5 344 0 358 0 0 0 0 0 5a5a0344 0 5a5a0358 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// all lanes on bank 0, cold and then resident
0 f 1060 1170 1280 1390 0 0 0 0 5a5a1060 5a5a1170 5a5a1280 5a5a1390 4 0
0 f 1064 1174 1284 1394 0 0 0 0 5a5a1064 5a5a1174 5a5a1284 5a5a1394 0 0
0 3 1a0 2a0 0 0 0 0 0 0 5a5a01a0 5a5a02a0 0 0 2 0
// write allocate then read back
1 f 4b0 4b4 4b8 4bc 11110000 22220001 33330002 44440003 0 0 0 0 1 0
0 f 4b0 4b4 4b8 4bc 0 0 0 0 11110000 22220001 33330002 44440003 0 0
1 2 0 214 0 0 0 deadbeef 0 0 0 0 0 0 0 0
0 3 210 214 0 0 0 0 0 0 5a5a0210 deadbeef 0 0 0 0
// dirty evictions, then the old line comes back from memory
0 1 5b0 0 0 0 0 0 0 0 5a5a05b0 0 0 0 1 1
0 f 4b0 4b4 4b8 4bc 0 0 0 0 11110000 22220001 33330002 44440003 1 0
0 1 310 0 0 0 0 0 0 0 5a5a0310 0 0 0 1 1
0 2 0 214 0 0 0 0 0 0 0 deadbeef 0 0 1 0
1 3 6c0 7d4 0 0 a5a5a5a5 5a5a5a5a 0 0 0 0 0 0 2 0
1 1 8c0 0 0 0 12345678 0 0 0 0 0 0 0 1 1
0 f 6c0 7d4 8c8 8cc 0 0 0 0 a5a5a5a5 5a5a5a5a 5a5a08c8 5a5a08cc 1 1
0 1 8c0 0 0 0 0 0 0 0 12345678 0 0 0 1 0
// serialized write hits on one bank
1 f 1060 1170 1280 1390 0a0a0001 0a0a0002 0a0a0003 0a0a0004 0 0 0 0 0 0
0 f 1060 1170 1280 1390 0 0 0 0 0a0a0001 0a0a0002 0a0a0003 0a0a0004 0 0
0 1 2060 0 0 0 0 0 0 0 5a5a2060 0 0 0 1 1
0 1 1060 0 0 0 0 0 0 0 0a0a0001 0 0 0 1 0
